//--- Bender.yml
package:
  name: exu

sources:
  - files:
      - source/exu_pkg.sv
      - source/exu_alu.sv
      - source/exu_csr.sv
      - source/exu_branch.sv
      - source/exu_stage.sv
      - source/data_ram.sv
      - source/exu_top.sv
  - target: simulation
    files:
      - bench/exu_tb.sv

//--- bench/exu_golden.txt
# op alu_op csr_op rd src1 src2 imm pc csr_addr | expected rd_wdata redirect npc
# all fields hex, one instruction per line, in issue order
0 0 0 01 00001234 00000010 00000000 00000100 000 00001244 0 00000104
0 1 0 02 00000005 00000008 00000000 00000104 000 fffffffd 0 00000108
0 7 0 03 80000010 00000004 00000000 00000108 000 f8000001 0 0000010c
0 9 0 04 00000001 ffffffff 00000000 0000010c 000 00000001 0 00000110
0 4 0 05 ff00ff00 0f0f0f0f 00000000 00000110 000 f00ff00f 0 00000114
0 0 0 00 00000007 00000009 00000000 00000114 000 00000000 0 00000118
1 c 0 00 00000042 00000042 00000020 00000118 000 00000000 1 00000138
1 c 0 00 00000042 00000043 00000020 0000011c 000 00000000 0 00000120
1 d 0 00 00000001 00000002 fffffff0 00000120 000 00000000 1 00000110
1 d 0 00 00000003 00000003 00000040 00000124 000 00000000 0 00000128
2 0 0 01 00000000 00000000 00000100 00000128 000 0000012c 1 00000228
3 0 0 01 00001001 00000000 00000004 0000012c 000 00000130 1 00001004
5 0 0 00 00000040 deadbeef 00000008 00000130 000 00000000 0 00000134
4 0 0 06 00000040 00000000 00000008 00000134 000 deadbeef 0 00000138
4 0 0 07 00000080 00000000 00000000 00000138 000 00000000 0 0000013c
6 0 0 08 00000800 00000000 00000000 0000013c 305 00000000 0 00000140
6 0 1 09 00000000 00000000 00000000 00000140 305 00000800 0 00000144
6 0 1 08 00000004 00000000 00000000 00000144 305 00000800 0 00000148
6 0 1 09 00000000 00000000 00000000 00000148 305 00000804 0 0000014c
6 0 2 0a 00000080 00000000 00000000 0000014c 300 00000080 0 00000150
6 0 1 0b 00000000 00000000 00000000 00000150 300 00000000 0 00000154
7 0 0 00 00000000 00000000 00000000 00000154 000 00000000 1 00000804
6 0 1 0c 00000000 00000000 00000000 00000158 341 00000154 0 0000015c
6 0 1 0d 00000000 00000000 00000000 0000015c 342 0000000b 0 00000160
8 0 0 00 00000000 00000000 00000000 00000160 000 00000000 1 00000154
6 0 1 0e 00000000 00000000 00000000 00000164 300 00000080 0 00000168
8 0 0 00 00000000 00000000 00000000 00000168 000 00000000 1 00000154
6 0 1 0f 00000000 00000000 00000000 0000016c 300 00000088 0 00000170

//--- bench/exu_tb.sv
module exu_tb;
  import exu_pkg::*;

  localparam int MAX_VEC = 64;
  localparam int TIMEOUT = 100;

  logic            clk;
  logic            rst;
  logic            in_valid_i;
  logic            in_ready_o;
  exu_op_e         op_i;
  alu_op_e         alu_op_i;
  csr_op_e         csr_op_i;
  logic [4:0]      rd_i;
  logic [XLEN-1:0] src1_i;
  logic [XLEN-1:0] src2_i;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] pc_i;
  logic [11:0]     csr_addr_i;
  logic            out_valid_o;
  logic            out_ready_i;
  logic [4:0]      rd_o;
  logic [XLEN-1:0] rd_wdata_o;
  logic            redirect_o;
  logic [XLEN-1:0] npc_o;

  // golden vectors, one entry per instruction
  logic [3:0]      v_op    [MAX_VEC];
  logic [3:0]      v_alu   [MAX_VEC];
  logic [1:0]      v_csr   [MAX_VEC];
  logic [4:0]      v_rd    [MAX_VEC];
  logic [XLEN-1:0] v_src1  [MAX_VEC];
  logic [XLEN-1:0] v_src2  [MAX_VEC];
  logic [XLEN-1:0] v_imm   [MAX_VEC];
  logic [XLEN-1:0] v_pc    [MAX_VEC];
  logic [11:0]     v_caddr [MAX_VEC];
  logic [XLEN-1:0] v_wdata [MAX_VEC];
  logic            v_redir [MAX_VEC];
  logic [XLEN-1:0] v_npc   [MAX_VEC];
  int              n_vec;
  logic [31:0]     lfsr;

  exu_top #(
    .RAM_WORDS   (256),
    .RAM_LATENCY (2)
  ) exu_top_inst (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .op_i        (op_i),
    .alu_op_i    (alu_op_i),
    .csr_op_i    (csr_op_i),
    .rd_i        (rd_i),
    .src1_i      (src1_i),
    .src2_i      (src2_i),
    .imm_i       (imm_i),
    .pc_i        (pc_i),
    .csr_addr_i  (csr_addr_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .rd_o        (rd_o),
    .rd_wdata_o  (rd_wdata_o),
    .redirect_o  (redirect_o),
    .npc_o       (npc_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // random back-pressure, one lfsr bit per cycle
  initial begin
    lfsr = 32'h636e_038e;
    forever begin
      @(posedge clk);
      #1;
      lfsr = lfsr_next(lfsr);
      out_ready_i = lfsr[0];
    end
  end

  task automatic end_with_failure(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_wdata(input int idx, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("Fail rd_wdata_o vector %0d: got 0x%h expected 0x%h", idx, got, exp);
      end_with_failure("rd_wdata_o mismatch");
    end
  endtask

  task automatic check_rd(input int idx, input logic [4:0] got, input logic [4:0] exp);
    if (got !== exp) begin
      $display("Fail rd_o vector %0d: got 0x%h expected 0x%h", idx, got, exp);
      end_with_failure("rd_o mismatch");
    end
  endtask

  task automatic check_redirect(input int idx, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail redirect_o vector %0d: got 0x%h expected 0x%h", idx, got, exp);
      end_with_failure("redirect_o mismatch");
    end
  endtask

  task automatic check_npc(input int idx, input logic [XLEN-1:0] got,
                           input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("Fail npc_o vector %0d: got 0x%h expected 0x%h", idx, got, exp);
      end_with_failure("npc_o mismatch");
    end
  endtask

  task automatic load_vectors();
    int    fd;
    int    cnt;
    string line;
    fd = $fopen("bench/exu_golden.txt", "r");
    if (fd == 0) begin
      end_with_failure("could not open bench/exu_golden.txt");
    end
    n_vec = 0;
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line.getc(0) != "#") begin
        if (n_vec >= MAX_VEC) begin
          end_with_failure("the golden file holds more vectors than the testbench can store");
        end
        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                      v_op[n_vec], v_alu[n_vec], v_csr[n_vec], v_rd[n_vec],
                      v_src1[n_vec], v_src2[n_vec], v_imm[n_vec], v_pc[n_vec],
                      v_caddr[n_vec], v_wdata[n_vec], v_redir[n_vec], v_npc[n_vec]);
        if (cnt != 12) begin
          end_with_failure("a line of the golden file does not have 12 fields");
        end
        n_vec++;
      end
    end
    $fclose(fd);
    if (n_vec == 0) begin
      end_with_failure("the golden file holds no vectors");
    end
  endtask

  task automatic drive_vector(input int idx);
    in_valid_i = 1'b1;
    op_i       = exu_op_e'(v_op[idx]);
    alu_op_i   = alu_op_e'(v_alu[idx]);
    csr_op_i   = csr_op_e'(v_csr[idx]);
    rd_i       = v_rd[idx];
    src1_i     = v_src1[idx];
    src2_i     = v_src2[idx];
    imm_i      = v_imm[idx];
    pc_i       = v_pc[idx];
    csr_addr_i = v_caddr[idx];
  endtask

  // in_ready_o is settled by the falling edge
  task automatic issue_all();
    int idx;
    int cycles;
    for (idx = 0; idx < n_vec; idx++) begin
      drive_vector(idx);
      cycles = 0;
      @(negedge clk);
      while (!in_ready_o && cycles < TIMEOUT) begin
        @(negedge clk);
        cycles++;
      end
      if (!in_ready_o) begin
        end_with_failure("in_ready_o stayed low for 100 cycles while issuing");
      end
      @(posedge clk);
      #1;
    end
    in_valid_i = 1'b0;
  endtask

  task automatic collect_results();
    int              idx;
    int              cycles;
    logic            done;
    logic            held;
    logic [4:0]      h_rd;
    logic [XLEN-1:0] h_wdata;
    logic            h_redir;
    logic [XLEN-1:0] h_npc;
    for (idx = 0; idx < n_vec; idx++) begin
      cycles = 0;
      done   = 1'b0;
      held   = 1'b0;
      while (!done) begin
        @(negedge clk);
        // a stalled result must not move
        if (held) begin
          if (!out_valid_o) begin
            end_with_failure("out_valid_o dropped before the result was taken");
          end
          check_rd(idx, rd_o, h_rd);
          check_wdata(idx, rd_wdata_o, h_wdata);
          check_redirect(idx, redirect_o, h_redir);
          check_npc(idx, npc_o, h_npc);
        end
        if (out_valid_o && out_ready_i) begin
          check_rd(idx, rd_o, v_rd[idx]);
          check_wdata(idx, rd_wdata_o, v_wdata[idx]);
          check_redirect(idx, redirect_o, v_redir[idx]);
          check_npc(idx, npc_o, v_npc[idx]);
          done = 1'b1;
        end else begin
          held    = out_valid_o;
          h_rd    = rd_o;
          h_wdata = rd_wdata_o;
          h_redir = redirect_o;
          h_npc   = npc_o;
          cycles++;
          if (cycles >= TIMEOUT) begin
            end_with_failure("no result on the retire port within 100 cycles");
          end
        end
      end
    end
  endtask

  initial begin
    rst         = 1'b1;
    in_valid_i  = 1'b0;
    op_i        = OP_ALU;
    alu_op_i    = ADD;
    csr_op_i    = CSRRW;
    rd_i        = '0;
    src1_i      = '0;
    src2_i      = '0;
    imm_i       = '0;
    pc_i        = '0;
    csr_addr_i  = '0;
    out_ready_i = 1'b0;
    load_vectors();
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    fork
      issue_all();
      collect_results();
    join
    // nothing more may come out
    repeat (5) begin
      @(negedge clk);
      if (out_valid_o) begin
        end_with_failure("an extra result appeared on the retire port after the last vector");
      end
    end
    $display("Regression passed");
    $finish;
  end

endmodule

//--- sim.f
source/exu_pkg.sv
source/exu_alu.sv
source/exu_csr.sv
source/exu_branch.sv
source/exu_stage.sv
source/data_ram.sv
source/exu_top.sv
bench/exu_tb.sv

//--- source/data_ram.sv
module data_ram #(
  parameter int RAM_WORDS   = 256,
  parameter int RAM_LATENCY = 2
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      req_i,
  input  logic                      we_i,
  input  logic [exu_pkg::XLEN-1:0]  addr_i,
  input  logic [exu_pkg::XLEN-1:0]  wdata_i,
  output logic                      rvalid_o,
  output logic [exu_pkg::XLEN-1:0]  rdata_o
);
  import exu_pkg::*;

  localparam int IDX_W = $clog2(RAM_WORDS);
  localparam int CNT_W = $clog2(RAM_LATENCY + 1);

  logic [XLEN-1:0]  mem_q [RAM_WORDS];
  logic [IDX_W-1:0] idx;
  logic [CNT_W-1:0] cnt_q;
  logic             busy_q;

  // word index, byte offset dropped
  assign idx      = addr_i[IDX_W+1:2];
  assign rvalid_o = busy_q && (cnt_q == CNT_W'(RAM_LATENCY));
  assign rdata_o  = mem_q[idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (!busy_q) begin
      busy_q <= req_i;
      cnt_q  <= CNT_W'(1);
    end else if (rvalid_o) begin
      busy_q <= 1'b0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < RAM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (rvalid_o && we_i) begin
      mem_q[idx] <= wdata_i;
    end
  end

endmodule

//--- source/exu_alu.sv
module exu_alu (
  input  exu_pkg::alu_op_e          op_i,
  input  logic [exu_pkg::XLEN-1:0]  a_i,
  input  logic [exu_pkg::XLEN-1:0]  b_i,
  output logic [exu_pkg::XLEN-1:0]  res_o
);
  import exu_pkg::*;

  logic [4:0] shamt;
  logic       cmp;

  assign shamt = b_i[4:0];

  // compare bit, placed in bit 0 of the result
  always_comb begin
    case (op_i)
      SLT:     cmp = $signed(a_i) < $signed(b_i);
      SLTU:    cmp = a_i < b_i;
      SGE:     cmp = $signed(a_i) >= $signed(b_i);
      SGEU:    cmp = a_i >= b_i;
      EQ:      cmp = a_i == b_i;
      NE:      cmp = a_i != b_i;
      default: cmp = 1'b0;
    endcase
  end

  always_comb begin
    case (op_i)
      ADD:     res_o = a_i + b_i;
      SUB:     res_o = a_i - b_i;
      AND:     res_o = a_i & b_i;
      OR:      res_o = a_i | b_i;
      XOR:     res_o = a_i ^ b_i;
      SLL:     res_o = a_i << shamt;
      SRL:     res_o = a_i >> shamt;
      SRA:     res_o = $unsigned($signed(a_i) >>> shamt);
      SLT, SLTU, SGE, SGEU, EQ, NE: begin
        res_o = {{(XLEN-1){1'b0}}, cmp};
      end
      default: res_o = '0;
    endcase
  end

endmodule

//--- source/exu_branch.sv
module exu_branch (
  input  exu_pkg::exu_op_e          op_i,
  input  exu_pkg::csr_op_e          csr_op_i,
  input  logic [exu_pkg::XLEN-1:0]  alu_res_i,
  input  logic [exu_pkg::XLEN-1:0]  pc_i,
  input  logic [exu_pkg::XLEN-1:0]  src1_i,
  input  logic [exu_pkg::XLEN-1:0]  imm_i,
  input  logic [exu_pkg::XLEN-1:0]  csr_rdata_i,
  input  logic [exu_pkg::XLEN-1:0]  mtvec_i,
  input  logic [exu_pkg::XLEN-1:0]  mepc_i,
  output logic                      redirect_o,
  output logic [exu_pkg::XLEN-1:0]  npc_o,
  output logic [exu_pkg::XLEN-1:0]  csr_wdata_o,
  output logic [exu_pkg::XLEN-1:0]  link_o
);
  import exu_pkg::*;

  logic [XLEN-1:0] pc_rel;
  logic [XLEN-1:0] jalr_tgt;

  assign pc_rel   = pc_i + imm_i;
  assign jalr_tgt = (src1_i + imm_i) & ~XLEN'(1);
  assign link_o   = pc_i + XLEN'(4);

  // branch taken on the compare bit only
  always_comb begin
    redirect_o = 1'b1;
    npc_o      = pc_rel;
    case (op_i)
      OP_BRANCH: begin
        redirect_o = alu_res_i[0];
        npc_o      = alu_res_i[0] ? pc_rel : link_o;
      end
      OP_JAL:   npc_o = pc_rel;
      OP_JALR:  npc_o = jalr_tgt;
      OP_ECALL: npc_o = mtvec_i;
      OP_MRET:  npc_o = mepc_i;
      default: begin
        redirect_o = 1'b0;
        npc_o      = link_o;
      end
    endcase
  end

  always_comb begin
    case (csr_op_i)
      CSRRW:   csr_wdata_o = src1_i;
      CSRRS:   csr_wdata_o = csr_rdata_i | src1_i;
      CSRRC:   csr_wdata_o = csr_rdata_i & ~src1_i;
      default: csr_wdata_o = csr_rdata_i;
    endcase
  end

endmodule

//--- source/exu_csr.sv
module exu_csr (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      commit_i,
  input  exu_pkg::exu_op_e          op_i,
  input  logic [11:0]               addr_i,
  input  logic [exu_pkg::XLEN-1:0]  wdata_i,
  input  logic [exu_pkg::XLEN-1:0]  pc_i,
  output logic [exu_pkg::XLEN-1:0]  rdata_o,
  output logic [exu_pkg::XLEN-1:0]  mtvec_o,
  output logic [exu_pkg::XLEN-1:0]  mepc_o
);
  import exu_pkg::*;

  logic [XLEN-1:0] mstatus_q;
  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] mcause_q;

  // unknown address reads zero
  always_comb begin
    case (addr_i)
      CSR_MSTATUS: rdata_o = mstatus_q;
      CSR_MTVEC:   rdata_o = mtvec_q;
      CSR_MEPC:    rdata_o = mepc_q;
      CSR_MCAUSE:  rdata_o = mcause_q;
      default:     rdata_o = '0;
    endcase
  end

  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= MSTATUS_RST;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else if (commit_i) begin
      case (op_i)
        OP_CSR: begin
          case (addr_i)
            CSR_MSTATUS: mstatus_q <= wdata_i;
            CSR_MTVEC:   mtvec_q   <= wdata_i;
            CSR_MEPC:    mepc_q    <= wdata_i;
            CSR_MCAUSE:  mcause_q  <= wdata_i;
            default: ;
          endcase
        end
        OP_ECALL: begin
          mepc_q   <= pc_i;
          mcause_q <= MCAUSE_ECALL_M;
        end
        // restore mie, mpie back to 1
        OP_MRET: begin
          mstatus_q[MSTATUS_MIE]  <= mstatus_q[MSTATUS_MPIE];
          mstatus_q[MSTATUS_MPIE] <= 1'b1;
        end
        default: ;
      endcase
    end
  end

endmodule

//--- source/exu_pkg.sv
package exu_pkg;

  localparam int XLEN = 32;

  // instruction class from decode
  typedef enum logic [3:0] {
    OP_ALU    = 4'd0,
    OP_BRANCH = 4'd1,
    OP_JAL    = 4'd2,
    OP_JALR   = 4'd3,
    OP_LOAD   = 4'd4,
    OP_STORE  = 4'd5,
    OP_CSR    = 4'd6,
    OP_ECALL  = 4'd7,
    OP_MRET   = 4'd8
  } exu_op_e;

  // compare ops from SLT onwards give 1 or 0
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    OR   = 4'd3,
    XOR  = 4'd4,
    SLL  = 4'd5,
    SRL  = 4'd6,
    SRA  = 4'd7,
    SLT  = 4'd8,
    SLTU = 4'd9,
    SGE  = 4'd10,
    SGEU = 4'd11,
    EQ   = 4'd12,
    NE   = 4'd13
  } alu_op_e;

  typedef enum logic [1:0] {
    CSRRW = 2'd0,
    CSRRS = 2'd1,
    CSRRC = 2'd2
  } csr_op_e;

  // machine csr addresses
  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_MTVEC   = 12'h305;
  localparam logic [11:0] CSR_MEPC    = 12'h341;
  localparam logic [11:0] CSR_MCAUSE  = 12'h342;

  localparam logic [XLEN-1:0] MCAUSE_ECALL_M = XLEN'(11);

  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;

  // mstatus comes out of reset with mpie set
  localparam logic [XLEN-1:0] MSTATUS_RST = XLEN'(1) << MSTATUS_MPIE;

endpackage

//--- source/exu_stage.sv
module exu_stage (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  exu_pkg::exu_op_e          op_i,
  input  exu_pkg::alu_op_e          alu_op_i,
  input  exu_pkg::csr_op_e          csr_op_i,
  input  logic [4:0]                rd_i,
  input  logic [exu_pkg::XLEN-1:0]  src1_i,
  input  logic [exu_pkg::XLEN-1:0]  src2_i,
  input  logic [exu_pkg::XLEN-1:0]  imm_i,
  input  logic [exu_pkg::XLEN-1:0]  pc_i,
  input  logic [11:0]               csr_addr_i,
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output logic [4:0]                rd_o,
  output logic [exu_pkg::XLEN-1:0]  rd_wdata_o,
  output logic                      redirect_o,
  output logic [exu_pkg::XLEN-1:0]  npc_o,
  output logic                      mem_req_o,
  output logic                      mem_we_o,
  output logic [exu_pkg::XLEN-1:0]  mem_addr_o,
  output logic [exu_pkg::XLEN-1:0]  mem_wdata_o,
  input  logic                      mem_rvalid_i,
  input  logic [exu_pkg::XLEN-1:0]  mem_rdata_i
);
  import exu_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    MEM_WAIT,
    DONE
  } state_e;

  state_e          state_q;
  exu_op_e         op_q;
  alu_op_e         alu_op_q;
  csr_op_e         csr_op_q;
  logic [4:0]      rd_q;
  logic [XLEN-1:0] src1_q;
  logic [XLEN-1:0] src2_q;
  logic [XLEN-1:0] imm_q;
  logic [XLEN-1:0] pc_q;
  logic [11:0]     csr_addr_q;
  logic [XLEN-1:0] load_q;

  logic            accept;
  logic            retire;
  logic            mem_resp;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] link;
  logic [XLEN-1:0] load_data;
  logic [XLEN-1:0] csr_rdata;
  logic [XLEN-1:0] csr_wdata;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] wb_data;

  assign mem_resp    = (state_q == MEM_WAIT) && mem_rvalid_i;
  // load result can retire in the response cycle itself
  assign out_valid_o = (state_q == DONE) || mem_resp;
  assign retire      = out_valid_o && out_ready_i;
  assign in_ready_o  = (state_q == IDLE) || retire;
  assign accept      = in_valid_i && in_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
    end else if (accept) begin
      state_q <= ((op_i == OP_LOAD) || (op_i == OP_STORE)) ? MEM_WAIT : DONE;
    end else if (retire) begin
      state_q <= IDLE;
    end else if (mem_resp) begin
      state_q <= DONE;
    end
  end

  // issue register, written only on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q       <= op_i;
      alu_op_q   <= alu_op_i;
      csr_op_q   <= csr_op_i;
      rd_q       <= rd_i;
      src1_q     <= src1_i;
      src2_q     <= src2_i;
      imm_q      <= imm_i;
      pc_q       <= pc_i;
      csr_addr_q <= csr_addr_i;
    end
    if (mem_resp) begin
      load_q <= mem_rdata_i;
    end
  end

  assign mem_req_o   = (state_q == MEM_WAIT);
  assign mem_we_o    = (state_q == MEM_WAIT) && (op_q == OP_STORE);
  assign mem_addr_o  = src1_q + imm_q;
  assign mem_wdata_o = src2_q;

  exu_alu exu_alu_inst (
    .op_i  (alu_op_q),
    .a_i   (src1_q),
    .b_i   (src2_q),
    .res_o (alu_res)
  );

  exu_csr exu_csr_inst (
    .clk      (clk),
    .rst      (rst),
    .commit_i (retire),
    .op_i     (op_q),
    .addr_i   (csr_addr_q),
    .wdata_i  (csr_wdata),
    .pc_i     (pc_q),
    .rdata_o  (csr_rdata),
    .mtvec_o  (mtvec),
    .mepc_o   (mepc)
  );

  exu_branch exu_branch_inst (
    .op_i        (op_q),
    .csr_op_i    (csr_op_q),
    .alu_res_i   (alu_res),
    .pc_i        (pc_q),
    .src1_i      (src1_q),
    .imm_i       (imm_q),
    .csr_rdata_i (csr_rdata),
    .mtvec_i     (mtvec),
    .mepc_i      (mepc),
    .redirect_o  (redirect_o),
    .npc_o       (npc_o),
    .csr_wdata_o (csr_wdata),
    .link_o      (link)
  );

  assign load_data = mem_resp ? mem_rdata_i : load_q;

  always_comb begin
    case (op_q)
      OP_ALU:          wb_data = alu_res;
      OP_JAL, OP_JALR: wb_data = link;
      OP_LOAD:         wb_data = load_data;
      OP_CSR:          wb_data = csr_rdata;
      default:         wb_data = '0;
    endcase
  end

  assign rd_o       = rd_q;
  assign rd_wdata_o = (rd_q == 5'd0) ? '0 : wb_data;

endmodule

//--- source/exu_top.sv
module exu_top #(
  parameter int RAM_WORDS   = 256,
  parameter int RAM_LATENCY = 2
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  exu_pkg::exu_op_e          op_i,
  input  exu_pkg::alu_op_e          alu_op_i,
  input  exu_pkg::csr_op_e          csr_op_i,
  input  logic [4:0]                rd_i,
  input  logic [exu_pkg::XLEN-1:0]  src1_i,
  input  logic [exu_pkg::XLEN-1:0]  src2_i,
  input  logic [exu_pkg::XLEN-1:0]  imm_i,
  input  logic [exu_pkg::XLEN-1:0]  pc_i,
  input  logic [11:0]               csr_addr_i,
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output logic [4:0]                rd_o,
  output logic [exu_pkg::XLEN-1:0]  rd_wdata_o,
  output logic                      redirect_o,
  output logic [exu_pkg::XLEN-1:0]  npc_o
);
  import exu_pkg::*;

  logic            mem_req;
  logic            mem_we;
  logic [XLEN-1:0] mem_addr;
  logic [XLEN-1:0] mem_wdata;
  logic            mem_rvalid;
  logic [XLEN-1:0] mem_rdata;

  exu_stage exu_stage_inst (
    .clk          (clk),
    .rst          (rst),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .op_i         (op_i),
    .alu_op_i     (alu_op_i),
    .csr_op_i     (csr_op_i),
    .rd_i         (rd_i),
    .src1_i       (src1_i),
    .src2_i       (src2_i),
    .imm_i        (imm_i),
    .pc_i         (pc_i),
    .csr_addr_i   (csr_addr_i),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .rd_o         (rd_o),
    .rd_wdata_o   (rd_wdata_o),
    .redirect_o   (redirect_o),
    .npc_o        (npc_o),
    .mem_req_o    (mem_req),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_rvalid_i (mem_rvalid),
    .mem_rdata_i  (mem_rdata)
  );

  data_ram #(
    .RAM_WORDS   (RAM_WORDS),
    .RAM_LATENCY (RAM_LATENCY)
  ) data_ram_inst (
    .clk      (clk),
    .rst      (rst),
    .req_i    (mem_req),
    .we_i     (mem_we),
    .addr_i   (mem_addr),
    .wdata_i  (mem_wdata),
    .rvalid_o (mem_rvalid),
    .rdata_o  (mem_rdata)
  );

endmodule
